// ==== common/pi_bus_pkg.sv ====
`default_nettype none

package pi_bus_pkg;

   // word addressed bus
   typedef logic [29:0] pi_addr_t;   // word address
   typedef logic [31:0] pi_data_t;   // data word
   typedef logic [3:0]  pi_opc_t;    // transfer opcode

   // opcodes seen on the bus
   localparam pi_opc_t OPC_SINGLE = 4'h0;   // single word transfer
   localparam pi_opc_t OPC_BURST2 = 4'h1;   // two word burst, answered with error
   localparam pi_opc_t OPC_BURST4 = 4'h2;   // four word burst, answered with error
   localparam pi_opc_t OPC_RMW    = 4'h8;   // read modify write, answered with error

   // acknowledge code, driven by the slave every data phase cycle
   typedef enum logic [1:0] {
      ACK_IDLE = 2'b00,   // no transfer or aborted
      ACK_RDY  = 2'b01,   // transfer done
      ACK_WAT  = 2'b10,   // slave busy, master holds
      ACK_ERR  = 2'b11    // bad address or opcode
   } pi_ack_e;

   // the whole address phase
   typedef struct packed {
      logic     sel;    // slave select
      logic     read;   // 1 read, 0 write
      pi_opc_t  opc;
      pi_addr_t addr;
   } pi_req_t;

endpackage

`default_nettype wire

// ==== common/pi_slave_pkg.sv ====
`default_nettype none

package pi_slave_pkg;

   // slave sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,        // nothing latched
      ST_ADDRESS,     // request latched, first data cycle next
      ST_DATA_WAIT    // answered with wait, retry each cycle
   } slave_state_e;

   // storage geometry
   localparam int DEV_WORDS    = 16;   // words in the device window
   localparam int WBUF_DEPTH   = 4;    // posted write entries
   localparam int DRAIN_PERIOD = 4;    // cycles per drained word

   typedef logic [3:0] dev_index_t;    // memory word index

   // device status toward the sequencer
   typedef struct packed {
      logic filled;       // write buffer full
      logic data_ready;   // buffer empty, reads coherent
      logic error;        // address outside the window
   } dev_status_t;

   // one command per completed transfer
   typedef struct packed {
      logic                 wr_en;   // push into write buffer
      logic                 rd_en;   // read consumed
      pi_bus_pkg::pi_addr_t addr;
      pi_bus_pkg::pi_data_t wdata;
   } dev_cmd_t;

endpackage

`default_nettype wire

// ==== pi_slave/pi_slave_fsm.sv ====
`default_nettype none

module pi_slave_fsm (
   input  logic                      clk,
   input  logic                      reset,
   input  pi_bus_pkg::pi_req_t       req,        // address phase from master
   input  pi_bus_pkg::pi_data_t      din,        // write data, held until answered
   input  logic                      tout,       // bus timeout
   input  pi_slave_pkg::dev_status_t status,     // device status for cur_addr
   input  pi_bus_pkg::pi_data_t      rdata,      // device word at cur_addr
   output pi_slave_pkg::dev_cmd_t    cmd,
   output pi_bus_pkg::pi_addr_t      cur_addr,   // latched word address
   output pi_bus_pkg::pi_ack_e       ack,
   output pi_bus_pkg::pi_data_t      dout
);

   pi_slave_pkg::slave_state_e state;
   pi_bus_pkg::pi_opc_t        opc_q;      // latched opcode
   logic                       read_q;     // latched direction
   logic                       busy;       // a transfer is in its data phase
   logic                       xfer_err;   // bad opcode or address
   logic                       abort;      // timeout while waiting
   logic                       can_done;   // device can take or give the word
   logic                       done;       // transfer ends this edge, rdy or err
   logic                       take;       // latch a new address phase
   logic                       wr_en_q;
   logic                       rd_en_q;
   pi_bus_pkg::pi_addr_t       cmd_addr_q;
   pi_bus_pkg::pi_data_t       wdata_q;

   assign busy     = (state != pi_slave_pkg::ST_IDLE);
   assign xfer_err = status.error || (opc_q != pi_bus_pkg::OPC_SINGLE);
   assign abort    = (state == pi_slave_pkg::ST_DATA_WAIT) && tout && !xfer_err;
   assign can_done = read_q ? status.data_ready : !status.filled;
   assign done     = busy && (xfer_err || (!abort && can_done));
   assign take     = req.sel && (!busy || done);   // next request overlaps completion

   // address phase capture
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         cur_addr <= req.addr;
         opc_q    <= req.opc;
         read_q   <= req.read;
      end
   end

   // sequencer
   always_ff @(posedge clk)
   begin
      if (reset)
         state <= pi_slave_pkg::ST_IDLE;
      else if (take)
         state <= pi_slave_pkg::ST_ADDRESS;       // back to back, stay in data phase
      else if (done || abort)
         state <= pi_slave_pkg::ST_IDLE;
      else if (busy)
         state <= pi_slave_pkg::ST_DATA_WAIT;     // device not ready yet
   end

   // bus answer, one decision per edge
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack  <= pi_bus_pkg::ACK_IDLE;
         dout <= '0;
      end
      else if (!busy || abort)
      begin
         ack  <= pi_bus_pkg::ACK_IDLE;            // idle or dropped transfer
         dout <= '0;
      end
      else if (xfer_err)
      begin
         ack  <= pi_bus_pkg::ACK_ERR;             // one cycle, nothing stored
         dout <= '0;
      end
      else if (can_done)
      begin
         ack  <= pi_bus_pkg::ACK_RDY;
         dout <= read_q ? rdata : '0;
      end
      else
      begin
         ack  <= pi_bus_pkg::ACK_WAT;
         dout <= '0;
      end
   end

   // device strobes, one cycle pulse after a good completion
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_en_q <= 1'b0;
         rd_en_q <= 1'b0;
      end
      else
      begin
         wr_en_q <= done && !xfer_err && !read_q;
         rd_en_q <= done && !xfer_err && read_q;
      end
   end

   // cur_addr may move on at the same edge so keep our own copy
   always_ff @(posedge clk)
   begin
      if (done)
         cmd_addr_q <= cur_addr;
      if (done && !read_q)
         wdata_q <= din;                          // din sampled at completion
   end

   assign cmd = '{wr_en: wr_en_q, rd_en: rd_en_q, addr: cmd_addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// ==== pi_slave/pi_slave_device.sv ====
`default_nettype none

module pi_slave_device #(
   parameter int WBUF_DEPTH = pi_slave_pkg::WBUF_DEPTH   // posted write entries, >= 1
) (
   input  logic                      clk,
   input  logic                      reset,
   input  pi_slave_pkg::dev_cmd_t    cmd,
   input  pi_bus_pkg::pi_addr_t      cur_addr,
   output pi_slave_pkg::dev_status_t status,
   output pi_bus_pkg::pi_data_t      rdata
);

   localparam int PTR_W   = (WBUF_DEPTH > 1) ? $clog2(WBUF_DEPTH) : 1;
   localparam int CNT_W   = $clog2(WBUF_DEPTH + 1);
   localparam int DRAIN_W = $clog2(pi_slave_pkg::DRAIN_PERIOD + 1);
   localparam int IDX_W   = $bits(pi_slave_pkg::dev_index_t);

   pi_slave_pkg::dev_index_t wb_idx  [WBUF_DEPTH];               // buffered word index
   pi_bus_pkg::pi_data_t     wb_data [WBUF_DEPTH];               // buffered write data
   pi_bus_pkg::pi_data_t     mem     [pi_slave_pkg::DEV_WORDS];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;                             // oldest entry
   logic [CNT_W-1:0]         count;                              // entries held
   logic [DRAIN_W-1:0]       drain_cnt;
   logic                     push;
   logic                     pop;
   logic                     empty;

   // wrap for any depth, not only powers of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(WBUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign push  = cmd.wr_en;   // filled lookahead keeps this off when full
   assign pop   = !empty && (drain_cnt == DRAIN_W'(pi_slave_pkg::DRAIN_PERIOD - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         drain_cnt <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // none or both
         endcase
         if (empty || pop)
            drain_cnt <= '0;                      // restart drain interval
         else
            drain_cnt <= drain_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         wb_idx[wr_ptr]  <= cmd.addr[IDX_W-1:0];
         wb_data[wr_ptr] <= cmd.wdata;
      end
   end

   // drain oldest entry into the word memory
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < pi_slave_pkg::DEV_WORDS; i++)
            mem[i] <= '0;
      end
      else if (pop)
         mem[wb_idx[rd_ptr]] <= wb_data[rd_ptr];
   end

   // a strobed write is counted before it lands in the buffer
   assign status = '{
      filled:     (int'(count) + int'(cmd.wr_en)) >= WBUF_DEPTH,
      data_ready: empty && !cmd.wr_en,
      error:      cur_addr >= pi_bus_pkg::pi_addr_t'(pi_slave_pkg::DEV_WORDS)
   };

   assign rdata = mem[cur_addr[IDX_W-1:0]];       // only used when in window

endmodule

`default_nettype wire

// ==== design/pi_slave_top.sv ====
`default_nettype none

module pi_slave_top (
   input  logic                 clk,
   input  logic                 reset,
   input  pi_bus_pkg::pi_req_t  req,    // address phase
   input  pi_bus_pkg::pi_data_t din,    // write data
   input  logic                 tout,   // bus timeout
   output pi_bus_pkg::pi_ack_e  ack,
   output pi_bus_pkg::pi_data_t dout
);

   pi_slave_pkg::dev_cmd_t    cmd;        // sequencer to device
   pi_slave_pkg::dev_status_t status;     // device to sequencer
   pi_bus_pkg::pi_addr_t      cur_addr;   // address under decode
   pi_bus_pkg::pi_data_t      rdata;

   pi_slave_fsm u_fsm (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .din      (din),
      .tout     (tout),
      .status   (status),
      .rdata    (rdata),
      .cmd      (cmd),
      .cur_addr (cur_addr),
      .ack      (ack),
      .dout     (dout)
   );

   // storage behind the slave, default buffer depth
   pi_slave_device u_dev (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd),
      .cur_addr (cur_addr),
      .status   (status),
      .rdata    (rdata)
   );

endmodule

`default_nettype wire

// ==== verification/pi_slave_asserts.sv ====
`default_nettype none

module pi_slave_asserts (
   input logic                   clk,
   input logic                   reset,
   input pi_bus_pkg::pi_ack_e    ack,
   input pi_bus_pkg::pi_data_t   dout,
   input pi_slave_pkg::dev_cmd_t cmd
);

   int fail_count = 0;   // failed assertions so far

   a_idle_after_reset : assert property (@(posedge clk) reset |=> ack == pi_bus_pkg::ACK_IDLE)
   else
   begin
      $error("ack not idle after reset");
      fail_count++;
   end

   a_one_strobe : assert property (@(posedge clk) disable iff (reset)
                                   !(cmd.wr_en && cmd.rd_en))
   else
   begin
      $error("wr_en and rd_en high together");
      fail_count++;
   end

   // a stored write was answered ready, never error
   a_no_err_on_write : assert property (@(posedge clk) disable iff (reset)
                                        cmd.wr_en |-> ack != pi_bus_pkg::ACK_ERR)
   else
   begin
      $error("error ack with a write strobe");
      fail_count++;
   end

   a_quiet_dout : assert property (@(posedge clk) disable iff (reset)
                                   (ack == pi_bus_pkg::ACK_IDLE || ack == pi_bus_pkg::ACK_ERR)
                                   |-> dout == '0)
   else
   begin
      $error("dout not zero on idle or error ack");
      fail_count++;
   end

endmodule

bind pi_slave_fsm pi_slave_asserts u_asserts (
   .clk   (clk),
   .reset (reset),
   .ack   (ack),
   .dout  (dout),
   .cmd   (cmd)
);

`default_nettype wire

// ==== verification/pi_slave_tb.sv ====
`default_nettype none

module pi_slave_tb;

   localparam int WAIT_LIMIT = 100;   // cycles one transfer may stall

   logic                 clk;
   logic                 reset;
   pi_bus_pkg::pi_req_t  req;
   pi_bus_pkg::pi_data_t din;
   logic                 tout;
   pi_bus_pkg::pi_ack_e  ack;
   pi_bus_pkg::pi_data_t dout;

   pi_bus_pkg::pi_data_t shadow [pi_slave_pkg::DEV_WORDS];   // expected memory contents
   pi_bus_pkg::pi_req_t  seq_req [$];                        // next run of transfers
   pi_bus_pkg::pi_data_t seq_din [$];
   pi_bus_pkg::pi_ack_e  exp_ack [$];
   pi_bus_pkg::pi_data_t exp_data [$];
   pi_bus_pkg::pi_ack_e  got_ack [$];                        // seen on the bus
   pi_bus_pkg::pi_data_t got_data [$];
   int                   xfer_no   = 0;
   int                   ack_errs  = 0;
   int                   data_errs = 0;
   int                   misc_errs = 0;
   int                   wat_seen  = 0;                      // wait cycles so far

   pi_slave_top UUT (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .din   (din),
      .tout  (tout),
      .ack   (ack),
      .dout  (dout)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   // expected answer per request, shadow updated on good writes only
   function automatic pi_bus_pkg::pi_ack_e ref_mem(input pi_bus_pkg::pi_req_t r,
         input pi_bus_pkg::pi_data_t wdata, input logic drop, output pi_bus_pkg::pi_data_t rd);
      rd = '0;
      if (r.opc != pi_bus_pkg::OPC_SINGLE ||
          r.addr >= pi_bus_pkg::pi_addr_t'(pi_slave_pkg::DEV_WORDS))
         return pi_bus_pkg::ACK_ERR;               // error wins over timeout
      if (drop)
         return pi_bus_pkg::ACK_IDLE;              // aborted, nothing stored
      if (r.read)
         rd = shadow[pi_slave_pkg::dev_index_t'(r.addr)];
      else
         shadow[pi_slave_pkg::dev_index_t'(r.addr)] = wdata;
      return pi_bus_pkg::ACK_RDY;
   endfunction

   task automatic check_ack(input pi_bus_pkg::pi_ack_e got, input pi_bus_pkg::pi_ack_e exp);
      if (got !== exp)
      begin
         ack_errs++;
         $display("ERR %0t transfer %0d ack %s, expected %s", $time, xfer_no, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_data(input pi_bus_pkg::pi_data_t got, input pi_bus_pkg::pi_data_t exp);
      if (got !== exp)
      begin
         data_errs++;
         $display("ERR %0t transfer %0d dout %h, expected %h", $time, xfer_no, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      misc_errs++;
      $display("timeout, %s", what);
      $display("sim failed");
      $finish;
   endtask

   task automatic queue_xfer(input logic rd, input pi_bus_pkg::pi_opc_t opc,
         input pi_bus_pkg::pi_addr_t addr, input pi_bus_pkg::pi_data_t wdata);
      pi_bus_pkg::pi_req_t r;
      r = '{sel: 1'b1, read: rd, opc: opc, addr: addr};
      seq_req.push_back(r);
      seq_din.push_back(wdata);
   endtask

   // issue queued transfers with sel held high, one address per completion
   task automatic run_queued(input logic drop_last);
      int                   n;
      int                   cyc;
      int                   idx;
      pi_bus_pkg::pi_ack_e  a;
      pi_bus_pkg::pi_data_t rd;
      n = seq_req.size();
      for (int i = 0; i < n; i++)
      begin
         a = ref_mem(seq_req[i], seq_din[i], drop_last && (i == n - 1), rd);
         exp_ack.push_back(a);
         exp_data.push_back(rd);
      end
      cyc = 0;
      idx = 0;
      while (idx < n && cyc <= n + WAIT_LIMIT)
      begin
         @(posedge clk);
         if (cyc < n)
         begin
            req  <= seq_req[cyc];
            tout <= drop_last && (cyc == n - 1);   // armed with the last request
         end
         else if (cyc == n)
            req.sel <= 1'b0;                       // last one latched
         if (cyc >= 1 && cyc <= n)
            din <= seq_din[cyc - 1];               // data one cycle behind address
         @(negedge clk);
         if (ack == pi_bus_pkg::ACK_WAT)
            wat_seen++;
         if (cyc >= 2 && (idx < n - 1 || ack != pi_bus_pkg::ACK_WAT))
         begin
            got_ack.push_back(ack);                // only the last may stall
            got_data.push_back(dout);
            idx++;
         end
         cyc++;
      end
      if (idx < n)
         stop_on_timeout("a transfer never left the wait state");
      else
      begin
         seq_req.delete();
         seq_din.delete();
      end
   endtask

   initial
   begin
      forever
      begin
         @(posedge clk);
         while (got_ack.size() > 0)
         begin
            xfer_no++;
            check_ack(got_ack.pop_front(), exp_ack.pop_front());
            check_data(got_data.pop_front(), exp_data.pop_front());
         end
      end
   end

   initial
   begin
      pi_bus_pkg::pi_addr_t a;
      int                   wat_before;
      int                   settle;
      void'($urandom(32'h44ecdc0c));
      reset = 1'b1;
      req   = '0;
      din   = '0;
      tout  = 1'b0;
      foreach (shadow[i])
         shadow[i] = '0;
      repeat (4)
         @(posedge clk);
      reset <= 1'b0;
      repeat (6)
      begin
         queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, $urandom_range(15), '0);   // fresh memory
         run_queued(1'b0);
      end
      repeat (4)
      begin
         a = $urandom_range(pi_slave_pkg::DEV_WORDS - 1);
         queue_xfer(1'b0, pi_bus_pkg::OPC_SINGLE, a, $urandom);
         queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, a, '0);   // held by data_ready
         run_queued(1'b0);
      end
      wat_before = wat_seen;
      repeat (24)
      begin
         queue_xfer(1'b0, pi_bus_pkg::OPC_SINGLE, $urandom_range(15), $urandom);
         run_queued(1'b0);
      end
      if (wat_seen == wat_before)
      begin
         misc_errs++;
         $display("the write burst never saw a wait state");
      end
      for (int i = 0; i < pi_slave_pkg::DEV_WORDS; i++)
      begin
         queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, i, '0);
         run_queued(1'b0);
      end
      a = pi_slave_pkg::DEV_WORDS * (1 + $urandom_range(6)) + 3;   // aliases word 3
      queue_xfer(1'b0, pi_bus_pkg::OPC_SINGLE, a, $urandom);
      queue_xfer(1'b0, pi_bus_pkg::OPC_RMW, 3, $urandom);
      queue_xfer(1'b1, pi_bus_pkg::OPC_BURST4, 5, '0);
      queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, 20, '0);
      queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, 3, '0);     // untouched by both bad writes
      run_queued(1'b0);
      for (int i = 0; i < 5; i++)
         queue_xfer(1'b0, pi_bus_pkg::OPC_SINGLE, i + 8, $urandom);   // fifth hits full buffer
      run_queued(1'b1);
      queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, 12, '0);    // old word still there
      run_queued(1'b0);
      for (int i = 0; i < 9; i++)
         queue_xfer(1'b1, pi_bus_pkg::OPC_SINGLE, (i == 4) ? 40 : $urandom_range(15), '0);
      run_queued(1'b0);
      settle = 0;
      while (got_ack.size() != 0 && settle < 20)
      begin
         @(posedge clk);
         settle++;
      end
      if (got_ack.size() != 0)
         stop_on_timeout("results were left uncompared");
      else
      begin
         $display("ack errors %0d, data errors %0d, other errors %0d, assertion failures %0d",
                  ack_errs, data_errs, misc_errs, UUT.u_fsm.u_asserts.fail_count);
         if (ack_errs + data_errs + misc_errs + UUT.u_fsm.u_asserts.fail_count == 0)
            $display("sim passed");
         else
            $display("sim failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
common/pi_bus_pkg.sv
common/pi_slave_pkg.sv
pi_slave/pi_slave_fsm.sv
pi_slave/pi_slave_device.sv
design/pi_slave_top.sv
verification/pi_slave_asserts.sv
verification/pi_slave_tb.sv

// ==== Bender.yml ====
package:
  name: pi_slave

sources:
  - common/pi_bus_pkg.sv
  - common/pi_slave_pkg.sv
  - pi_slave/pi_slave_fsm.sv
  - pi_slave/pi_slave_device.sv
  - design/pi_slave_top.sv
  - target: test
    files:
      - verification/pi_slave_asserts.sv
      - verification/pi_slave_tb.sv
